/* common/isa_pkg.sv */
// RV64I base integer set only; no compressed, CSR or system encodings
package isa_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int NUM_GPR    = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011; // addiw and word shifts
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word seen through each format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

/* common/pipe_pkg.sv */
// stage buses follow the valid/allowin handshake; field order is fixed for all stages
package pipe_pkg;

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASS2 = 4'd10; // lui

  localparam int MEM_OP_W = 3; // load/store funct3

  // alu operand selects
  localparam logic       SRC1_RS1  = 1'b0;
  localparam logic       SRC1_PC   = 1'b1;
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2; // link address pc+4

  typedef struct packed {
    logic [isa_pkg::ILEN-1:0] inst;
    logic [isa_pkg::XLEN-1:0] pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                     taken;
    logic [isa_pkg::XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic                           wen;
    logic [isa_pkg::GPR_ADDR_W-1:0] waddr;
    logic [isa_pkg::XLEN-1:0]       wdata;
  } ws_to_rf_t;

  typedef struct packed {
    logic [isa_pkg::GPR_ADDR_W-1:0] rs1;
    logic [isa_pkg::GPR_ADDR_W-1:0] rs2;
    logic [isa_pkg::GPR_ADDR_W-1:0] rd;
    logic                           rs1_used;
    logic                           rs2_used;
    logic [isa_pkg::XLEN-1:0]       imm;
    logic                           bren;
    logic [2:0]                     brfunc;
    logic                           jump;
    logic                           jump_reg; // jalr
    logic                           alu_src1_sel;
    logic [1:0]                     alu_src2_sel;
    logic                           alu_word;
    logic [ALU_OP_W-1:0]            alu_op;
    logic                           gpr_wen;
    logic                           mem_ren;
    logic                           mem_wen;
    logic [MEM_OP_W-1:0]            mem_op;
    logic                           invalid;
  } dec_ctrl_t;

  typedef struct packed {
    logic [isa_pkg::XLEN-1:0]       rs1data;
    logic [isa_pkg::XLEN-1:0]       rs2data;
    logic [isa_pkg::XLEN-1:0]       pc;
    logic [isa_pkg::XLEN-1:0]       imm;
    logic [isa_pkg::GPR_ADDR_W-1:0] rs1;
    logic [isa_pkg::GPR_ADDR_W-1:0] rs2;
    logic [isa_pkg::GPR_ADDR_W-1:0] rd;
    logic                           alu_src1_sel;
    logic [1:0]                     alu_src2_sel;
    logic                           alu_word;
    logic [ALU_OP_W-1:0]            alu_op;
    logic                           gpr_wen;
    logic                           mem_ren;
    logic                           mem_wen;
    logic [MEM_OP_W-1:0]            mem_op;
    logic                           invalid;
  } ds_to_es_t;

endpackage

/* source/gpr_file.sv */
// read is combinational with no write bypass; a write shows after its edge
`timescale 1ns/1ns

module gpr_file (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_raddr1,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_raddr2,
  output logic [isa_pkg::XLEN-1:0]       o_rdata1,
  output logic [isa_pkg::XLEN-1:0]       o_rdata2,
  input  pipe_pkg::ws_to_rf_t            i_wr
);
  import isa_pkg::*;

  logic [XLEN-1:0] regs [NUM_GPR];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int k = 0; k < NUM_GPR; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin
      regs[i_wr.waddr] <= i_wr.wdata; // x0 stays zero
    end
  end

  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  // holds across any sequence of write-back traffic
  a_x0_reads_zero: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      (i_raddr1 != '0 || o_rdata1 == '0) && (i_raddr2 != '0 || o_rdata2 == '0)
  );

endmodule

/* id_decoder/id_decoder.sv */
// only the major opcode is checked for validity; funct fields are decoded as given
`timescale 1ns/1ns

module id_decoder (
  input  isa_pkg::inst_u      i_inst,
  output pipe_pkg::dec_ctrl_t o_ctrl
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            alt; // funct7[5], sub and sra
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  function automatic logic [ALU_OP_W-1:0] alu_from_f3(input logic [2:0] f3,
                                                      input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;
  assign alt    = i_inst.r.funct7[5];

  // sign-extended immediates, one per format
  assign imm_i = {{(XLEN-12){i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_s = {{(XLEN-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{(XLEN-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{(XLEN-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{(XLEN-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    o_ctrl              = '0;
    o_ctrl.rs1          = i_inst.r.rs1;
    o_ctrl.rs2          = i_inst.r.rs2;
    o_ctrl.rd           = i_inst.r.rd;
    o_ctrl.brfunc       = funct3;
    o_ctrl.mem_op       = funct3; // size and sign straight from funct3
    o_ctrl.alu_op       = ALU_ADD;
    o_ctrl.alu_src1_sel = SRC1_RS1;
    o_ctrl.alu_src2_sel = SRC2_RS2;
    case (opcode)
      OP_LUI: begin
        o_ctrl.imm          = imm_u;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.alu_op       = ALU_PASS2;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_AUIPC: begin
        o_ctrl.imm          = imm_u;
        o_ctrl.alu_src1_sel = SRC1_PC;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        o_ctrl.imm          = (opcode == OP_JAL) ? imm_j : imm_i;
        o_ctrl.rs1_used     = (opcode == OP_JALR);
        o_ctrl.jump         = 1'b1;
        o_ctrl.jump_reg     = (opcode == OP_JALR);
        o_ctrl.alu_src1_sel = SRC1_PC; // rd gets pc+4
        o_ctrl.alu_src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_BRANCH: begin
        o_ctrl.imm      = imm_b;
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.rs2_used = 1'b1;
        o_ctrl.bren     = 1'b1;
      end
      OP_LOAD: begin
        o_ctrl.imm          = imm_i;
        o_ctrl.rs1_used     = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_STORE: begin
        o_ctrl.imm          = imm_s;
        o_ctrl.rs1_used     = 1'b1;
        o_ctrl.rs2_used     = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.mem_wen      = 1'b1;
      end
      OP_IMM, OP_IMM32: begin
        o_ctrl.imm          = imm_i;
        o_ctrl.rs1_used     = 1'b1;
        o_ctrl.alu_src2_sel = SRC2_IMM;
        o_ctrl.alu_word     = (opcode == OP_IMM32);
        o_ctrl.alu_op       = alu_from_f3(funct3, alt && funct3 == 3'b101); // no subi
        o_ctrl.gpr_wen      = 1'b1;
      end
      OP_REG, OP_REG32: begin
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.rs2_used = 1'b1;
        o_ctrl.alu_word = (opcode == OP_REG32);
        o_ctrl.alu_op   = alu_from_f3(funct3, alt);
        o_ctrl.gpr_wen  = 1'b1;
      end
      default: o_ctrl.invalid = 1'b1; // no enables, passed on as is
    endcase
  end

endmodule

/* id_stage/ds_slot.sv */
// one-entry stage register; wrong-path drop only covers the fetch offered on the taken edge
`timescale 1ns/1ns

module ds_slot (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_fs_valid,
  input  pipe_pkg::fs_to_ds_t i_fs_bus,
  output logic                o_ds_allowin,
  input  logic                i_ready_go,
  input  logic                i_es_allowin,
  output logic                o_ds_valid,
  output logic                o_ds_to_es_valid,
  output pipe_pkg::fs_to_ds_t o_slot,
  input  pipe_pkg::br_bus_t   i_br
);

  logic wrong_path;
  logic load;

  assign o_ds_allowin     = !o_ds_valid || (i_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = o_ds_valid && i_ready_go;

  // taken implies the held branch leaves on this edge
  assign wrong_path = i_br.taken && (i_fs_bus.pc != i_br.target);
  assign load       = i_fs_valid && o_ds_allowin && !wrong_path;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      o_ds_valid <= load; // empty when nothing new or dropped
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      o_slot <= i_fs_bus;
    end
  end

  // held instruction survives a stalled handoff untouched
  a_hold_under_backpressure: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      (o_ds_to_es_valid && !i_es_allowin) |=> (o_ds_valid && $stable(o_slot))
  );

endmodule

/* id_stage/hazard_check.sv */
// stall-only interlock, no forwarding; x0 as a pending destination never stalls
`timescale 1ns/1ns

module hazard_check (
  input  logic                           i_ds_valid,
  input  pipe_pkg::dec_ctrl_t            i_ctrl,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_ws_rd,
  output logic                           o_ready_go
);
  import isa_pkg::*;

  logic [GPR_ADDR_W-1:0] pend_rd [3];
  logic [2:0]            hit;

  always_comb begin
    pend_rd[0] = i_es_rd;
    pend_rd[1] = i_ms_rd;
    pend_rd[2] = i_ws_rd;
    for (int k = 0; k < 3; k++) begin
      hit[k] = (pend_rd[k] != '0) &&
               ((i_ctrl.rs1_used && pend_rd[k] == i_ctrl.rs1) ||
                (i_ctrl.rs2_used && pend_rd[k] == i_ctrl.rs2));
    end
  end

  assign o_ready_go = !(i_ds_valid && |hit);

endmodule

/* id_stage/branch_unit.sv */
// resolves in decode from register file data; funct3 010/011 under a branch opcode never take
`timescale 1ns/1ns

module branch_unit (
  input  logic                     i_ds_valid,
  input  logic                     i_ready_go,
  input  logic [isa_pkg::XLEN-1:0] i_pc,
  input  pipe_pkg::dec_ctrl_t      i_ctrl,
  input  logic [isa_pkg::XLEN-1:0] i_rs1data,
  input  logic [isa_pkg::XLEN-1:0] i_rs2data,
  output pipe_pkg::br_bus_t        o_br
);
  import isa_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic [XLEN-1:0] jalr_sum;

  assign eq  = i_rs1data == i_rs2data;
  assign lt  = $signed(i_rs1data) < $signed(i_rs2data);
  assign ltu = i_rs1data < i_rs2data;

  always_comb begin
    case (i_ctrl.brfunc)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = !eq;
      F3_BLT:  cond = lt;
      F3_BGE:  cond = !lt;
      F3_BLTU: cond = ltu;
      F3_BGEU: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + i_ctrl.imm;

  // only an instruction that can leave this cycle redirects fetch
  assign o_br.taken  = i_ds_valid && i_ready_go &&
                       (i_ctrl.jump || (i_ctrl.bren && cond));
  assign o_br.target = i_ctrl.jump_reg ? {jalr_sum[XLEN-1:1], 1'b0}
                                       : i_pc + i_ctrl.imm;

endmodule

/* id_stage/id_stage.sv */
// decode stage only; CSR, ecall/mret and ebreak are not decoded and come out as invalid
`timescale 1ns/1ns

module id_stage (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  // from fetch
  input  logic                           i_fs_valid,
  input  pipe_pkg::fs_to_ds_t            i_fs_bus,
  output logic                           o_ds_allowin,
  // to execute
  output logic                           o_ds_to_es_valid,
  output pipe_pkg::ds_to_es_t            o_ds_to_es_bus,
  input  logic                           i_es_allowin,
  // back to fetch
  output pipe_pkg::br_bus_t              o_br_bus,
  // write-back port
  input  pipe_pkg::ws_to_rf_t            i_ws_to_rf,
  // pending destinations, 0 for none
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_ws_rd
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic            ds_valid;
  logic            ready_go;
  fs_to_ds_t       slot;
  dec_ctrl_t       ctrl;
  logic [XLEN-1:0] rs1data;
  logic [XLEN-1:0] rs2data;

  ds_slot u_slot (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_bus         (i_fs_bus),
    .o_ds_allowin     (o_ds_allowin),
    .i_ready_go       (ready_go),
    .i_es_allowin     (i_es_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_slot           (slot),
    .i_br             (o_br_bus)
  );

  id_decoder u_decoder (
    .i_inst (slot.inst),
    .o_ctrl (ctrl)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (ctrl.rs1),
    .i_raddr2 (ctrl.rs2),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data),
    .i_wr     (i_ws_to_rf)
  );

  hazard_check u_hazard (
    .i_ds_valid (ds_valid),
    .i_ctrl     (ctrl),
    .i_es_rd    (i_es_rd),
    .i_ms_rd    (i_ms_rd),
    .i_ws_rd    (i_ws_rd),
    .o_ready_go (ready_go)
  );

  branch_unit u_branch (
    .i_ds_valid (ds_valid),
    .i_ready_go (ready_go),
    .i_pc       (slot.pc),
    .i_ctrl     (ctrl),
    .i_rs1data  (rs1data),
    .i_rs2data  (rs2data),
    .o_br       (o_br_bus)
  );

  always_comb begin
    o_ds_to_es_bus.rs1data      = rs1data;
    o_ds_to_es_bus.rs2data      = rs2data;
    o_ds_to_es_bus.pc           = slot.pc;
    o_ds_to_es_bus.imm          = ctrl.imm;
    o_ds_to_es_bus.rs1          = ctrl.rs1;
    o_ds_to_es_bus.rs2          = ctrl.rs2;
    o_ds_to_es_bus.rd           = ctrl.rd;
    o_ds_to_es_bus.alu_src1_sel = ctrl.alu_src1_sel;
    o_ds_to_es_bus.alu_src2_sel = ctrl.alu_src2_sel;
    o_ds_to_es_bus.alu_word     = ctrl.alu_word;
    o_ds_to_es_bus.alu_op       = ctrl.alu_op;
    o_ds_to_es_bus.gpr_wen      = ctrl.gpr_wen;
    o_ds_to_es_bus.mem_ren      = ctrl.mem_ren;
    o_ds_to_es_bus.mem_wen      = ctrl.mem_wen;
    o_ds_to_es_bus.mem_op       = ctrl.mem_op;
    o_ds_to_es_bus.invalid      = ctrl.invalid;
  end

endmodule

/* dv/id_checker.sv */
// model assumes in-order single-slot decode and a register file without write bypass
`timescale 1ns/1ns

module id_checker (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  logic                           i_fs_valid,
  input  pipe_pkg::fs_to_ds_t            i_fs_bus,
  input  logic                           i_ds_allowin,
  input  logic                           i_ds_to_es_valid,
  input  pipe_pkg::ds_to_es_t            i_ds_to_es_bus,
  input  logic                           i_es_allowin,
  input  pipe_pkg::br_bus_t              i_br_bus,
  input  pipe_pkg::ws_to_rf_t            i_ws_to_rf,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_es_rd,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_ms_rd,
  input  logic [isa_pkg::GPR_ADDR_W-1:0] i_ws_rd,
  output int                             o_errors,
  output int                             o_checks,
  output int                             o_departs,
  output int                             o_discards,
  output int                             o_pending
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0] shadow [NUM_GPR];
  fs_to_ds_t       held_q [$];
  logic            was_in_rst = 1'b1;
  logic            was_stalled = 1'b0;
  ds_to_es_t       last_bus;

  task automatic check_val(input string sig, input logic [511:0] got, input logic [511:0] exp);
    o_checks++;
    if (got !== exp) begin
      o_errors++;
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, sig, got, exp);
    end
  endtask

  function automatic logic [ALU_OP_W-1:0] alu_expect(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic ds_to_es_t model_bus(input fs_to_ds_t f, output logic use1,
                                          output logic use2);
    inst_u              w;
    ds_to_es_t          b;
    logic signed [11:0] si;
    logic signed [11:0] ss;
    logic signed [12:0] sb;
    logic signed [31:0] su;
    logic signed [20:0] sj;
    w  = f.inst;
    si = w.i.imm_11_0;
    ss = {w.s.imm_11_5, w.s.imm_4_0};
    sb = {w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
    su = {w.u.imm_31_12, 12'h000};
    sj = {w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
    b         = '0;
    b.rs1     = w.r.rs1;
    b.rs2     = w.r.rs2;
    b.rd      = w.r.rd;
    b.rs1data = shadow[w.r.rs1];
    b.rs2data = shadow[w.r.rs2];
    b.pc      = f.pc;
    b.mem_op  = w.r.funct3;
    b.alu_op  = ALU_ADD;
    use1      = 1'b1;
    use2      = 1'b0;
    case (w.r.opcode)
      OP_LUI, OP_AUIPC: begin
        b.imm          = 64'(su);
        b.alu_src2_sel = SRC2_IMM;
        b.alu_src1_sel = (w.r.opcode == OP_AUIPC) ? SRC1_PC : SRC1_RS1;
        b.alu_op       = (w.r.opcode == OP_LUI) ? ALU_PASS2 : ALU_ADD;
        b.gpr_wen      = 1'b1;
        use1           = 1'b0;
      end
      OP_JAL, OP_JALR: begin
        b.imm          = (w.r.opcode == OP_JAL) ? 64'(sj) : 64'(si);
        b.alu_src1_sel = SRC1_PC; // link value pc+4
        b.alu_src2_sel = SRC2_FOUR;
        b.gpr_wen      = 1'b1;
        use1           = (w.r.opcode == OP_JALR);
      end
      OP_BRANCH: begin
        b.imm = 64'(sb);
        use2  = 1'b1;
      end
      OP_LOAD, OP_STORE: begin
        b.imm          = (w.r.opcode == OP_LOAD) ? 64'(si) : 64'(ss);
        b.alu_src2_sel = SRC2_IMM;
        b.mem_ren      = (w.r.opcode == OP_LOAD);
        b.mem_wen      = (w.r.opcode == OP_STORE);
        b.gpr_wen      = (w.r.opcode == OP_LOAD);
        use2           = (w.r.opcode == OP_STORE);
      end
      OP_IMM, OP_IMM32: begin
        b.imm          = 64'(si);
        b.alu_src2_sel = SRC2_IMM;
        b.alu_word     = (w.r.opcode == OP_IMM32);
        b.alu_op       = alu_expect(w.r.funct3, w.r.funct7[5] && w.r.funct3 == 3'd5);
        b.gpr_wen      = 1'b1;
      end
      OP_REG, OP_REG32: begin
        b.alu_word = (w.r.opcode == OP_REG32);
        b.alu_op   = alu_expect(w.r.funct3, w.r.funct7[5]);
        b.gpr_wen  = 1'b1;
        use2       = 1'b1;
      end
      default: begin
        b.invalid = 1'b1;
        use1      = 1'b0;
      end
    endcase
    return b;
  endfunction

  function automatic br_bus_t model_br(input fs_to_ds_t f, input ds_to_es_t b);
    inst_u           w;
    logic            cond;
    br_bus_t         r;
    logic [XLEN-1:0] sum;
    w = f.inst;
    case (w.b.funct3)
      F3_BEQ:  cond = b.rs1data == b.rs2data;
      F3_BNE:  cond = b.rs1data != b.rs2data;
      F3_BLT:  cond = $signed(b.rs1data) < $signed(b.rs2data);
      F3_BGE:  cond = $signed(b.rs1data) >= $signed(b.rs2data);
      F3_BLTU: cond = b.rs1data < b.rs2data;
      F3_BGEU: cond = b.rs1data >= b.rs2data;
      default: cond = 1'b0;
    endcase
    sum      = b.rs1data + b.imm;
    r.target = (w.r.opcode == OP_JALR) ? {sum[XLEN-1:1], 1'b0} : f.pc + b.imm;
    r.taken  = (w.r.opcode == OP_JAL) || (w.r.opcode == OP_JALR) ||
               (w.r.opcode == OP_BRANCH && cond);
    return r;
  endfunction

  function automatic logic src_pending(input logic [GPR_ADDR_W-1:0] src, input logic used);
    return used && src != '0 && (src == i_es_rd || src == i_ms_rd || src == i_ws_rd);
  endfunction

  always @(posedge i_clk) begin : watch
    ds_to_es_t exp_bus;
    br_bus_t   exp_br;
    logic      use1;
    logic      use2;
    logic      head_ok;
    logic      exp_go;
    logic      exp_allowin;
    exp_bus = '0;
    exp_br  = '0;
    use1    = 1'b0;
    use2    = 1'b0;
    head_ok = held_q.size() > 0;
    if (!i_rst_n) begin
      held_q.delete();
      for (int k = 0; k < NUM_GPR; k++) begin
        shadow[k] = '0;
      end
      was_in_rst  = 1'b1;
      was_stalled = 1'b0;
    end else begin
      if (was_in_rst) begin // first edge out of reset
        check_val("o_ds_to_es_valid after reset", 512'(i_ds_to_es_valid), 512'(0));
        check_val("o_br_bus.taken after reset", 512'(i_br_bus.taken), 512'(0));
        check_val("o_ds_allowin after reset", 512'(i_ds_allowin), 512'(1));
      end
      was_in_rst = 1'b0;
      if (head_ok) begin
        exp_bus = model_bus(held_q[0], use1, use2);
        exp_br  = model_br(held_q[0], exp_bus);
      end
      exp_go       = head_ok && !src_pending(exp_bus.rs1, use1) &&
                     !src_pending(exp_bus.rs2, use2);
      exp_br.taken = exp_br.taken && exp_go;
      exp_allowin  = !head_ok || (exp_go && i_es_allowin);
      check_val("o_ds_to_es_valid", 512'(i_ds_to_es_valid), 512'(exp_go));
      check_val("o_ds_allowin", 512'(i_ds_allowin), 512'(exp_allowin));
      check_val("o_br_bus.taken", 512'(i_br_bus.taken), 512'(exp_br.taken));
      if (exp_br.taken) begin
        check_val("o_br_bus.target", 512'(i_br_bus.target), 512'(exp_br.target));
      end
      if (exp_go) begin
        check_val("o_ds_to_es_bus", 512'(i_ds_to_es_bus), 512'(exp_bus));
      end
      if (was_stalled) begin // operand data may move with write-back
        exp_bus         = i_ds_to_es_bus;
        exp_bus.rs1data = '0;
        exp_bus.rs2data = '0;
        check_val("o_ds_to_es_bus held", 512'(exp_bus), 512'(last_bus));
      end
      last_bus         = i_ds_to_es_bus;
      last_bus.rs1data = '0;
      last_bus.rs2data = '0;
      was_stalled      = exp_go && !i_es_allowin;
      if (exp_go && i_es_allowin) begin
        void'(held_q.pop_front());
        o_departs++;
      end
      if (i_fs_valid && exp_allowin) begin
        if (exp_br.taken && i_fs_bus.pc != exp_br.target) begin
          o_discards++;
        end else begin
          held_q.push_back(i_fs_bus);
        end
      end
      if (i_ws_to_rf.wen && i_ws_to_rf.waddr != '0) begin
        shadow[i_ws_to_rf.waddr] = i_ws_to_rf.wdata;
      end
    end
    o_pending = held_q.size();
  end

endmodule

/* dv/tb_top.sv */
// random traffic from one fixed seed; branch targets are hit by replaying the held target
`timescale 1ns/1ns

module tb_top;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int RST_CYCLES  = 10;
  localparam int STALL_LIMIT = 500;
  localparam int DRAIN_LIMIT = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  fs_valid;
  fs_to_ds_t             fs_bus;
  logic                  ds_allowin;
  logic                  ds_valid;
  ds_to_es_t             ds_bus;
  logic                  es_allowin;
  br_bus_t               br_bus;
  ws_to_rf_t             ws_to_rf;
  logic [GPR_ADDR_W-1:0] es_rd;
  logic [GPR_ADDR_W-1:0] ms_rd;
  logic [GPR_ADDR_W-1:0] ws_rd;
  logic [31:0]           lcg_state;
  logic                  timed_out;
  int                    tests;
  int                    bad_tests;
  int                    errors;
  int                    checks;
  int                    departs;
  int                    discards;
  int                    pending;

  always #5 clk = ~clk;

  id_stage DUT (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_valid       (fs_valid),
    .i_fs_bus         (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (ds_valid),
    .o_ds_to_es_bus   (ds_bus),
    .i_es_allowin     (es_allowin),
    .o_br_bus         (br_bus),
    .i_ws_to_rf       (ws_to_rf),
    .i_es_rd          (es_rd),
    .i_ms_rd          (ms_rd),
    .i_ws_rd          (ws_rd)
  );

  id_checker u_check (
    .i_clk (clk), .i_rst_n (rst_n), .i_fs_valid (fs_valid), .i_fs_bus (fs_bus),
    .i_ds_allowin (ds_allowin), .i_ds_to_es_valid (ds_valid), .i_ds_to_es_bus (ds_bus),
    .i_es_allowin (es_allowin), .i_br_bus (br_bus), .i_ws_to_rf (ws_to_rf),
    .i_es_rd (es_rd), .i_ms_rd (ms_rd), .i_ws_rd (ws_rd),
    .o_errors (errors), .o_checks (checks), .o_departs (departs),
    .o_discards (discards), .o_pending (pending)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:8] % 24'd100) < pct;
  endfunction

  function automatic logic [31:0] rand_inst();
    logic [6:0]  ops [11] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                              OP_STORE, OP_IMM, OP_IMM32, OP_REG, OP_REG32};
    logic [31:0] w;
    logic [31:0] r;
    int          k;
    w = next_rand();
    r = next_rand();
    k = int'(r[31:8] % 24'd11);
    w[6:0] = chance(6) ? 7'b1110011 : ops[k]; // system opcode, not decoded
    return w;
  endfunction

  // pending destination: copy a held source, clear, or keep
  function automatic logic [GPR_ADDR_W-1:0] pick_rd(input logic [GPR_ADDR_W-1:0] cur,
                                                    input int hz);
    logic [31:0] r;
    r = next_rand();
    if (chance(hz)) return r[20] ? ds_bus.rs1 : ds_bus.rs2;
    if (chance(35)) return '0;
    if (chance(5)) return r[28:24];
    return cur;
  endfunction

  task automatic drive_cycle(input int hz, input int bp, input int tg);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    fs_valid       <= chance(80);
    fs_bus.inst    <= rand_inst();
    fs_bus.pc      <= chance(tg) ? br_bus.target : {hi, lo[31:2], 2'b00};
    es_allowin     <= !chance(bp);
    ws_to_rf.wen   <= chance(50);
    ws_to_rf.waddr <= hi[12:8];
    ws_to_rf.wdata <= {lo, hi};
    es_rd          <= pick_rd(es_rd, hz);
    ms_rd          <= pick_rd(ms_rd, hz);
    ws_rd          <= pick_rd(ws_rd, hz);
  endtask

  task automatic report_test(input string name, input int err0, input int dep0,
                             input int disc0);
    @(negedge clk);
    tests++;
    if (errors != err0) bad_tests++;
    $display("test %s departures %0d discards %0d new errors %0d", name,
             departs - dep0, discards - disc0, errors - err0);
  endtask

  task automatic run_test(input string name, input int cycles, input int hz, input int bp,
                          input int tg);
    int err0;
    int dep0;
    int disc0;
    int stuck;
    err0  = errors;
    dep0  = departs;
    disc0 = discards;
    stuck = 0;
    for (int c = 0; c < cycles && !timed_out; c++) begin
      @(posedge clk);
      stuck = ds_allowin ? 0 : stuck + 1;
      if (stuck > STALL_LIMIT) begin
        $display("decode stage kept allowin low for %0d cycles in test %s", stuck, name);
        timed_out = 1'b1;
      end else begin
        drive_cycle(hz, bp, tg);
      end
    end
    report_test(name, err0, dep0, disc0);
  endtask

  initial begin
    int n;
    clk       = 1'b0;
    rst_n     = 1'b0;
    fs_valid  = 1'b0;
    fs_bus    = '0;
    es_allowin = 1'b0;
    ws_to_rf  = '0;
    es_rd     = '0;
    ms_rd     = '0;
    ws_rd     = '0;
    lcg_state = 32'h24c2_4f11;
    timed_out = 1'b0;
    tests     = 0;
    bad_tests = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    report_test("reset", 0, 0, 0);
    run_test("mixed", 2000, 5, 20, 10);
    run_test("interlock", 2000, 30, 10, 5);
    run_test("backpressure", 2000, 5, 70, 10);
    run_test("redirect", 2000, 3, 15, 60);
    @(posedge clk);
    fs_valid   <= 1'b0;
    es_allowin <= 1'b1;
    es_rd      <= '0;
    ms_rd      <= '0;
    ws_rd      <= '0;
    n = 0;
    @(negedge clk);
    while (!timed_out && pending != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0 && !timed_out) begin
      $display("%0d accepted instructions never left the stage", pending);
      timed_out = 1'b1;
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, bad_tests, checks,
             errors);
    if (errors == 0 && bad_tests == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* sim.f */
common/isa_pkg.sv
common/pipe_pkg.sv
source/gpr_file.sv
id_decoder/id_decoder.sv
id_stage/ds_slot.sv
id_stage/hazard_check.sv
id_stage/branch_unit.sv
id_stage/id_stage.sv
dv/id_checker.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run; fails unless the pass message is printed"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	@out="$$(./$(OBJ_DIR)/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
